/* tb.f */
src/stream_pkg.sv
src/ram_2p.sv
src/asym_ram_2p.sv
src/frame_padder.sv
src/width_fifo.sv
src/frame_summer.sv
src/byte_to_word_top.sv
tests/byte_to_word_sva.sv
tests/tb_top.sv

/* Makefile */
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
		-Mdir $(OBJ_DIR) -f tb.f

run: compile
	./$(OBJ_DIR)/Vtb_top | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import stream_pkg::*; ();

   localparam int TIMEOUT = 2000;

   logic              clk_i;
   logic              rst_n_i;
   logic              in_valid_i;
   logic [BYTE_W-1:0] in_data_i;
   logic              in_last_i;
   logic              in_ready_o;
   logic              out_valid_o;
   logic [WORD_W-1:0] out_data_o;
   logic              out_last_o;
   logic [SUM_W-1:0]  out_sum_o;
   logic              out_ready_i;

   integer seed = 32'h7710;
   int     errors;
   int     checks;
   string  test_name;
   bit     check_en;
   int     ready_mode;

   // expected words in output order
   logic [WORD_W-1:0] exp_data_q [$];
   logic              exp_last_q [$];
   logic [SUM_W-1:0]  exp_sum_q  [$];

   byte_to_word_top #(
      .ADDR_W(4)
   ) dut (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_valid_i (in_valid_i),
      .in_data_i  (in_data_i),
      .in_last_i  (in_last_i),
      .in_ready_o (in_ready_o),
      .out_valid_o(out_valid_o),
      .out_data_o (out_data_o),
      .out_last_o (out_last_o),
      .out_sum_o  (out_sum_o),
      .out_ready_i(out_ready_i)
   );

   always #4 clk_i = ~clk_i;

   // ready_mode 0 gives random out_ready_i, 1 holds it low, 2 holds it high
   always @(posedge clk_i) begin : ready_gen
      logic rdy;
      case (ready_mode)
         0:       rdy = ({$random(seed)} % 4) != 0;
         1:       rdy = 1'b0;
         default: rdy = 1'b1;
      endcase
      #1;
      out_ready_i = rdy;
   end

   // outputs sampled at the falling edge before the transfer edge
   always @(negedge clk_i) begin : monitor
      logic [WORD_W-1:0] e_data;
      logic              e_last;
      logic [SUM_W-1:0]  e_sum;
      if (check_en && rst_n_i && out_valid_o && out_ready_i) begin
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("unexpected output word %h with nothing left to receive", out_data_o);
         end else begin
            e_data = exp_data_q.pop_front();
            e_last = exp_last_q.pop_front();
            e_sum  = exp_sum_q.pop_front();
            checks++;
            assert (out_data_o == e_data) else begin
               errors++;
               $display("[ERROR] %s: data expected %h, actual %h", test_name, e_data, out_data_o);
            end
            assert (out_last_o == e_last) else begin
               errors++;
               $display("[ERROR] %s: last expected %b, actual %b", test_name, e_last, out_last_o);
            end
            if (e_last) begin
               assert (out_sum_o == e_sum) else begin
                  errors++;
                  $display("[ERROR] %s: sum expected %h, actual %h", test_name, e_sum, out_sum_o);
               end
            end
         end
      end
   end

   task automatic abort_run(input string msg);
      $display("timeout: %s", msg);
      $display("Simulation failed");
      $finish;
   endtask

   task automatic check_reset_outputs();
      assert (!in_ready_o && !out_valid_o && !out_last_o) else begin
         errors++;
         $display("[ERROR] %s: ready/valid/last expected 000, actual %b%b%b",
                  test_name, in_ready_o, out_valid_o, out_last_o);
      end
   endtask

   // starts and ends 1 ns after a rising edge
   task automatic send_byte(input logic [BYTE_W-1:0] d, input logic last);
      int gap;
      int cnt;
      gap = {$random(seed)} % 3;
      repeat (gap) begin
         @(posedge clk_i);
         #1;
      end
      in_valid_i = 1'b1;
      in_data_i  = d;
      in_last_i  = last;
      cnt = 0;
      @(negedge clk_i);
      while (!in_ready_o) begin
         cnt++;
         if (cnt > TIMEOUT) abort_run("input byte was never accepted");
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      in_valid_i = 1'b0;
      in_data_i  = '0;
      in_last_i  = 1'b0;
   endtask

   // little-endian packing with zero pad and 16-bit byte sum
   task automatic send_frame(input int len);
      logic [BYTE_W-1:0] b;
      logic [WORD_W-1:0] w;
      logic [SUM_W-1:0]  s;
      int                padded;
      s = '0;
      w = '0;
      padded = ((len + LANES - 1) / LANES) * LANES;
      for (int i = 0; i < padded; i++) begin
         b = '0;
         if (i < len) begin
            b = BYTE_W'($random(seed));
            send_byte(b, i == len - 1);
         end
         w[(i % LANES)*BYTE_W +: BYTE_W] = b;
         s = s + SUM_W'(b);
         if (i % LANES == LANES - 1) begin
            exp_data_q.push_back(w);
            exp_last_q.push_back(i == padded - 1);
            exp_sum_q.push_back(s);
            w = '0;
         end
      end
   endtask

   task automatic wait_drain();
      int cnt;
      cnt = 0;
      while (exp_data_q.size() != 0) begin
         cnt++;
         if (cnt > TIMEOUT) abort_run("expected output words never arrived");
         @(posedge clk_i);
      end
      #1;
   endtask

   initial begin : main
      int cnt;
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      in_valid_i = 1'b0;
      in_data_i = '0;
      in_last_i = 1'b0;
      out_ready_i = 1'b0;
      errors = 0;
      checks = 0;
      check_en = 1'b0;
      ready_mode = 2;

      test_name = "reset";
      repeat (5) begin
         @(negedge clk_i);
         check_reset_outputs();
      end
      @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk_i);
      check_reset_outputs();
      @(posedge clk_i);
      #1;
      check_en = 1'b1;

      test_name = "packing";
      send_frame(4);
      send_frame(8);
      send_frame(1);
      send_frame(2);
      send_frame(3);
      send_frame(5);
      wait_drain();

      test_name = "random";
      ready_mode = 0;
      repeat (30) send_frame(1 + {$random(seed)} % 9);
      wait_drain();

      test_name = "backpressure";
      ready_mode = 1;
      fork
         begin
            send_frame(7);
            send_frame(9);
            send_frame(6);
         end
         begin
            repeat (40) @(posedge clk_i);
            #1;
            ready_mode = 0;
         end
      join
      wait_drain();

      test_name = "full";
      ready_mode = 1;
      fork
         send_frame(40);
         begin
            cnt = 0;
            @(negedge clk_i);
            while (!(in_valid_i && !in_ready_o)) begin
               cnt++;
               if (cnt > TIMEOUT) abort_run("in_ready_o never went low with a full buffer");
               @(negedge clk_i);
            end
            checks++;
            repeat (20) @(posedge clk_i);
            #1;
            ready_mode = 0;
         end
      join
      wait_drain();

      // reset while a frame is still open
      test_name = "reset_mid";
      check_en = 1'b0;
      ready_mode = 2;
      for (int i = 0; i < 8; i++) begin
         send_byte(BYTE_W'($random(seed)), 1'b0);
      end
      repeat (10) @(posedge clk_i);
      #1;
      rst_n_i = 1'b0;
      repeat (5) begin
         @(negedge clk_i);
         check_reset_outputs();
      end
      exp_data_q.delete();
      exp_last_q.delete();
      exp_sum_q.delete();
      @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      check_en = 1'b1;
      test_name = "fresh_sum";
      send_frame(6);
      send_frame(4);
      wait_drain();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* tests/byte_to_word_sva.sv */
`timescale 1ns/1ps

module byte_to_word_sva import stream_pkg::*; (
   input logic              clk_i,
   input logic              rst_n_i,
   input logic              in_ready_o,
   input logic              out_valid_o,
   input logic [WORD_W-1:0] out_data_o,
   input logic              out_last_o,
   input logic [SUM_W-1:0]  out_sum_o,
   input logic              out_ready_i
);

   // a stalled output word stays put
   property p_out_hold;
      @(posedge clk_i) disable iff (!rst_n_i)
         (out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(out_data_o) && $stable(out_last_o)
             && $stable(out_sum_o));
   endproperty

   // reset forces the handshake lines low
   property p_reset_low;
      @(posedge clk_i)
         !rst_n_i |-> (!in_ready_o && !out_valid_o && !out_last_o);
   endproperty

   property p_valid_known;
      @(posedge clk_i) disable iff (!rst_n_i)
         !$isunknown(out_valid_o);
   endproperty

   a_out_hold: assert property (p_out_hold)
      else $error("output changed while out_ready_i was low");

   a_reset_low: assert property (p_reset_low)
      else $error("handshake outputs not low during reset");

   a_valid_known: assert property (p_valid_known)
      else $error("out_valid_o is unknown after reset");

endmodule

bind byte_to_word_top byte_to_word_sva u_sva (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .in_ready_o (in_ready_o),
   .out_valid_o(out_valid_o),
   .out_data_o (out_data_o),
   .out_last_o (out_last_o),
   .out_sum_o  (out_sum_o),
   .out_ready_i(out_ready_i)
);

/* src/byte_to_word_top.sv */
`timescale 1ns/1ps

module byte_to_word_top import stream_pkg::*; #(
   parameter int ADDR_W = 6
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              in_valid_i,
   input  logic [BYTE_W-1:0] in_data_i,
   input  logic              in_last_i,
   output logic              in_ready_o,
   output logic              out_valid_o,
   output logic [WORD_W-1:0] out_data_o,
   output logic              out_last_o,
   output logic [SUM_W-1:0]  out_sum_o,
   input  logic              out_ready_i
);

   // padded byte stream
   logic              pad_valid;
   logic [BYTE_W-1:0] pad_data;
   logic              pad_last;
   logic              pad_ready;

   // word stream out of the buffer
   logic              fifo_valid;
   word_u             fifo_word;
   logic              fifo_last;
   logic              fifo_ready;

   frame_padder u_padder (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_valid_i (in_valid_i),
      .in_data_i  (in_data_i),
      .in_last_i  (in_last_i),
      .in_ready_o (in_ready_o),
      .pad_valid_o(pad_valid),
      .pad_data_o (pad_data),
      .pad_last_o (pad_last),
      .pad_ready_i(pad_ready)
   );

   width_fifo #(
      .ADDR_W(ADDR_W)
   ) u_fifo (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .wr_valid_i(pad_valid),
      .wr_data_i (pad_data),
      .wr_last_i (pad_last),
      .wr_ready_o(pad_ready),
      .rd_valid_o(fifo_valid),
      .rd_word_o (fifo_word),
      .rd_last_o (fifo_last),
      .rd_ready_i(fifo_ready)
   );

   frame_summer u_summer (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_valid_i (fifo_valid),
      .in_word_i  (fifo_word),
      .in_last_i  (fifo_last),
      .in_ready_o (fifo_ready),
      .out_valid_o(out_valid_o),
      .out_data_o (out_data_o),
      .out_last_o (out_last_o),
      .out_sum_o  (out_sum_o),
      .out_ready_i(out_ready_i)
   );

endmodule

/* src/frame_summer.sv */
`timescale 1ns/1ps

module frame_summer import stream_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              in_valid_i,
   input  word_u             in_word_i,
   input  logic              in_last_i,
   output logic              in_ready_o,
   output logic              out_valid_o,
   output logic [WORD_W-1:0] out_data_o,
   output logic              out_last_o,
   output logic [SUM_W-1:0]  out_sum_o,
   input  logic              out_ready_i
);

   logic [SUM_W-1:0]  sum_q;
   logic [SUM_W-1:0]  word_sum;
   logic [SUM_W-1:0]  new_sum;
   logic              take;
   logic              out_valid_q;
   logic              out_last_q;
   logic [WORD_W-1:0] out_data_q;
   logic [SUM_W-1:0]  out_sum_q;

   assign in_ready_o = !out_valid_q || out_ready_i;
   assign take       = in_valid_i && in_ready_o;

   // add the word's bytes, pad bytes are zero
   always_comb begin
      word_sum = '0;
      for (int i = 0; i < LANES; i++) begin
         word_sum = word_sum + SUM_W'(in_word_i.bytes[i]);
      end
   end

   assign new_sum = sum_q + word_sum;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
         out_last_q  <= 1'b0;
         sum_q       <= '0;
      end else begin
         if (take) begin
            out_valid_q <= 1'b1;
            out_last_q  <= in_last_i;
            // next frame starts from zero
            sum_q       <= in_last_i ? '0 : new_sum;
         end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         out_data_q <= in_word_i.word;
         out_sum_q  <= new_sum;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_data_o  = out_data_q;
   assign out_last_o  = out_last_q;
   assign out_sum_o   = out_sum_q;

endmodule

/* src/width_fifo.sv */
`timescale 1ns/1ps

module width_fifo import stream_pkg::*; #(
   parameter int ADDR_W = 6
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              wr_valid_i,
   input  logic [BYTE_W-1:0] wr_data_i,
   input  logic              wr_last_i,
   output logic              wr_ready_o,
   output logic              rd_valid_o,
   output word_u             rd_word_o,
   output logic              rd_last_o,
   input  logic              rd_ready_i
);

   localparam int LANE_W  = $clog2(LANES);
   localparam int WADDR_W = ADDR_W - LANE_W;
   localparam logic [ADDR_W:0]   DEPTH      = (ADDR_W + 1)'(2 ** ADDR_W);
   localparam logic [ADDR_W:0]   WORD_BYTES = (ADDR_W + 1)'(LANES);
   localparam logic [LANE_W-1:0] LANE_LAST  = LANE_W'(LANES - 1);

   logic [ADDR_W-1:0]  wr_ptr_q;
   logic [WADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W:0]    count_q;
   logic               last_mem [2**WADDR_W];
   logic               w_en;
   logic               r_en;
   logic               word_avail;
   logic               out_load;
   logic [WORD_W-1:0]  r_data;
   logic               ram_valid_q;
   logic               ram_last_q;
   logic               out_valid_q;
   logic               out_last_q;
   word_u              out_word_q;

   assign wr_ready_o = (count_q != DEPTH);
   assign w_en       = wr_valid_i && wr_ready_o;

   // at least one complete word stored
   assign word_avail = (count_q >= WORD_BYTES);
   assign out_load   = !out_valid_q || rd_ready_i;

   // prefetch when the RAM data register is empty or moving on
   assign r_en = word_avail && (!ram_valid_q || out_load);

   asym_ram_2p #(
      .W_DATA_W(BYTE_W),
      .R_DATA_W(WORD_W),
      .ADDR_W  (ADDR_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (w_en),
      .w_data_i(wr_data_i),
      .w_addr_i(wr_ptr_q),
      .r_en_i  (r_en),
      .r_addr_i({rd_ptr_q, {LANE_W{1'b0}}}),
      .r_data_o(r_data)
   );

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         ram_valid_q <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         if (w_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (r_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // bytes in, whole words out
         case ({w_en, r_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - WORD_BYTES;
            2'b11:   count_q <= count_q + 1'b1 - WORD_BYTES;
            default: count_q <= count_q;
         endcase
         if (r_en) begin
            ram_valid_q <= 1'b1;
         end else if (out_load) begin
            ram_valid_q <= 1'b0;
         end
         if (out_load) begin
            out_valid_q <= ram_valid_q;
         end
      end
   end

   // last flag kept per word, written with the top lane byte
   always_ff @(posedge clk_i) begin
      if (w_en && (wr_ptr_q[LANE_W-1:0] == LANE_LAST)) begin
         last_mem[wr_ptr_q[ADDR_W-1:LANE_W]] <= wr_last_i;
      end
      if (r_en) begin
         ram_last_q <= last_mem[rd_ptr_q];
      end
      if (out_load && ram_valid_q) begin
         out_word_q.word <= r_data;
         out_last_q      <= ram_last_q;
      end
   end

   assign rd_valid_o = out_valid_q;
   assign rd_word_o  = out_word_q;
   assign rd_last_o  = out_last_q;

endmodule

/* src/frame_padder.sv */
`timescale 1ns/1ps

module frame_padder import stream_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              in_valid_i,
   input  logic [BYTE_W-1:0] in_data_i,
   input  logic              in_last_i,
   output logic              in_ready_o,
   output logic              pad_valid_o,
   output logic [BYTE_W-1:0] pad_data_o,
   output logic              pad_last_o,
   input  logic              pad_ready_i
);

   localparam int LANE_W = $clog2(LANES);
   localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(LANES - 1);

   logic              run_q;
   logic              valid_q;
   logic              last_q;
   logic              pad_q;
   logic [LANE_W-1:0] lane_q;
   logic [BYTE_W-1:0] data_q;
   logic              load;
   logic              take;

   // output register free or draining this cycle
   assign load = !valid_q || pad_ready_i;

   // input blocked while zero bytes are being inserted
   assign in_ready_o = run_q && !pad_q && load;
   assign take       = in_valid_i && in_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         run_q   <= 1'b0;
         valid_q <= 1'b0;
         last_q  <= 1'b0;
         pad_q   <= 1'b0;
         lane_q  <= '0;
      end else begin
         run_q <= 1'b1;
         if (pad_q && load) begin
            // zero byte, the one in the top lane closes the frame
            valid_q <= 1'b1;
            last_q  <= (lane_q == LANE_LAST);
            pad_q   <= (lane_q != LANE_LAST);
            lane_q  <= lane_q + 1'b1;
         end else if (take) begin
            valid_q <= 1'b1;
            last_q  <= in_last_i && (lane_q == LANE_LAST);
            pad_q   <= in_last_i && (lane_q != LANE_LAST);
            lane_q  <= lane_q + 1'b1;
         end else if (pad_ready_i) begin
            valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (pad_q && load) begin
         data_q <= '0;
      end else if (take) begin
         data_q <= in_data_i;
      end
   end

   assign pad_valid_o = valid_q;
   assign pad_data_o  = data_q;
   assign pad_last_o  = last_q;

endmodule

/* src/asym_ram_2p.sv */
`timescale 1ns/1ps

module asym_ram_2p #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic                clk_i,
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic [ADDR_W-1:0]   w_addr_i,
   input  logic                r_en_i,
   input  logic [ADDR_W-1:0]   r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o
);

   // storage is N blocks of the narrower width
   localparam int MAXDATA_W  = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W  = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int N          = MAXDATA_W / MINDATA_W;
   localparam int N_W        = $clog2(N);
   localparam int SYMBOL_W   = $clog2(MINDATA_W / 8);
   localparam int BLK_ADDR_W = ADDR_W - N_W - SYMBOL_W;

   logic [N-1:0]         en_wr;
   logic [MINDATA_W-1:0] data_wr [N];
   logic [MINDATA_W-1:0] data_rd [N];

   // blocks share the high address bits
   for (genvar g = 0; g < N; g++) begin : g_blk
      ram_2p #(
         .DATA_W(MINDATA_W),
         .ADDR_W(BLK_ADDR_W)
      ) u_ram (
         .clk_i   (clk_i),
         .w_en_i  (en_wr[g]),
         .w_addr_i(w_addr_i[ADDR_W-1:N_W+SYMBOL_W]),
         .w_data_i(data_wr[g]),
         .r_en_i  (r_en_i),
         .r_addr_i(r_addr_i[ADDR_W-1:N_W+SYMBOL_W]),
         .r_data_o(data_rd[g])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_wr
      logic [N_W-1:0] r_lane_q;

      // wide write hits every block at once
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en_i;
            data_wr[j] = w_data_i[j*MINDATA_W +: MINDATA_W];
         end
      end

      // lane select follows the registered read data
      always_ff @(posedge clk_i) begin
         if (r_en_i) begin
            r_lane_q <= r_addr_i[SYMBOL_W +: N_W];
         end
      end

      always_comb begin
         r_data_o = data_rd[r_lane_q];
      end

   end else if (W_DATA_W < R_DATA_W) begin : g_narrow_wr

      // low address bits pick the one block to write
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en_i && (w_addr_i[SYMBOL_W +: N_W] == N_W'(j));
            data_wr[j] = w_data_i;
         end
      end

      // block k fills lane k of the read word
      always_comb begin
         for (int k = 0; k < N; k++) begin
            r_data_o[k*MINDATA_W +: MINDATA_W] = data_rd[k];
         end
      end

   end else begin : g_equal

      always_comb begin
         en_wr[0]   = w_en_i;
         data_wr[0] = w_data_i;
         r_data_o   = data_rd[0];
      end

   end

endmodule

/* src/ram_2p.sv */
`timescale 1ns/1ps

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read data register, holds while r_en_i is low
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* src/stream_pkg.sv */
package stream_pkg;

   // stream byte and output word geometry
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;
   localparam int LANES  = WORD_W / BYTE_W;

   // frame byte sum, wraps modulo 2^SUM_W
   localparam int SUM_W = 16;

   // one stored word, taken whole or as its bytes
   // byte 0 sits in bits 7:0 and is the first byte received
   typedef union packed {
      logic [WORD_W-1:0]            word;
      logic [LANES-1:0][BYTE_W-1:0] bytes;
   } word_u;

endpackage
